// File: design/fm_acc_top.sv
`timescale 1ns/10ps

module fm_acc_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clk_en,
    input  logic signed [fm_cfg_pkg::op_w-1:0]  op_result,
    input  logic                                pcm_en,
    input  logic [fm_cfg_pkg::op_w-1:0]         pcm,
    input  logic                                cfg_we,
    input  logic [2:0]                          cfg_ch,
    input  fm_cfg_pkg::fm_alg_e                 cfg_alg,
    input  logic [1:0]                          cfg_rl,
    output fm_bus_pkg::stereo_t                 snd,
    output logic                                sample_valid
);
    import fm_cfg_pkg::*;
    import fm_bus_pkg::*;

    slot_pos_t               slot;                 // Sequencer to selector
    acc_req_t                req;                  // Selector to both accumulators
    logic signed [snd_w-1:0] side_snd [2];         // Index 0 left, 1 right
    stereo_t                 pre;                  // Unscaled frame result

    fm_slot_seq slot_seq_i (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .slot   (slot)
    );

    fm_carrier_sel carrier_sel_i (
        .clk       (clk),
        .rst       (rst),
        .clk_en    (clk_en),
        .slot      (slot),
        .op_result (op_result),
        .pcm_en    (pcm_en),
        .pcm       (pcm),
        .cfg_we    (cfg_we),
        .cfg_ch    (cfg_ch),
        .cfg_alg   (cfg_alg),
        .cfg_rl    (cfg_rl),
        .req       (req)
    );

    // Left takes rl bit 1, right takes rl bit 0
    for (genvar i = 0; i < 2; i++) begin : g_side
        fm_side_acc side_acc_i (
            .clk    (clk),
            .rst    (rst),
            .clk_en (clk_en),
            .sample (req.sample),
            .zero   (req.zero),
            .sum_en (req.rl[1-i]),
            .snd    (side_snd[i])
        );
    end

    assign pre.left  = side_snd[0];
    assign pre.right = side_snd[1];

    fm_out_scale out_scale_i (
        .clk          (clk),
        .rst          (rst),
        .clk_en       (clk_en),
        .zero         (req.zero),
        .pre          (pre),
        .out          (snd),
        .sample_valid (sample_valid)
    );

endmodule

// File: design/fm_bus_pkg.sv
package fm_bus_pkg;

    // Position of the slot being served in the current enabled cycle
    typedef struct packed {
        logic [2:0]         ch;                    // Channel 0 to 5
        fm_cfg_pkg::fm_op_e grp;                   // Operator group of the slot
        logic               zero;                  // High in slot 0 only
    } slot_pos_t;

    // Word handed to both side accumulators once per slot
    typedef struct packed {
        logic signed [fm_cfg_pkg::op_w-1:0] sample; // Operator result or converted PCM
        logic                               zero;   // Frame start, closes the running sum
        logic [1:0]                         rl;     // Left in bit 1, right in bit 0
    } acc_req_t;

    // One stereo sample at accumulator width
    typedef struct packed {
        logic signed [fm_cfg_pkg::snd_w-1:0] left;
        logic signed [fm_cfg_pkg::snd_w-1:0] right;
    } stereo_t;

endpackage

// File: design/fm_carrier_sel.sv
`timescale 1ns/10ps

module fm_carrier_sel (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clk_en,
    input  fm_bus_pkg::slot_pos_t               slot,
    input  logic signed [fm_cfg_pkg::op_w-1:0]  op_result,
    input  logic                                pcm_en,
    input  logic [fm_cfg_pkg::op_w-1:0]         pcm,
    input  logic                                cfg_we,
    input  logic [2:0]                          cfg_ch,
    input  fm_cfg_pkg::fm_alg_e                 cfg_alg,
    input  logic [1:0]                          cfg_rl,
    output fm_bus_pkg::acc_req_t                req
);
    import fm_cfg_pkg::*;
    import fm_bus_pkg::*;

    fm_alg_e    alg_tbl [num_ch];                  // Algorithm per channel
    logic [1:0] rl_tbl  [num_ch];                  // Left/right enables per channel
    fm_alg_e    cur_alg;
    logic [1:0] cur_rl;
    logic       carrier;                           // Slot output reaches the mix
    logic       pcm_slot;                          // Slot belongs to the PCM channel in PCM mode
    logic       use_pcm;                           // Slot carries the PCM sample instead
    acc_req_t   req_nxt;

    // Configuration port writes regardless of clk_en
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_ch; i++) begin
                alg_tbl[i] <= alg0;
                rl_tbl[i]  <= 2'b11;               // Both sides on after reset
            end
        end else if (cfg_we && (cfg_ch < 3'(num_ch))) begin
            alg_tbl[cfg_ch] <= cfg_alg;
            rl_tbl[cfg_ch]  <= cfg_rl;
        end
    end

    assign cur_alg = alg_tbl[slot.ch];
    assign cur_rl  = rl_tbl[slot.ch];

    // Carrier membership from the channel algorithm and the operator group
    always_comb begin
        case (cur_alg)
            alg4:       carrier = (slot.grp == op_s2) || (slot.grp == op_s4);
            alg5, alg6: carrier = (slot.grp != op_s1);
            alg7:       carrier = 1'b1;
            default:    carrier = (slot.grp == op_s4);
        endcase
    end

    assign pcm_slot = pcm_en && (slot.ch == 3'(pcm_ch));
    assign use_pcm  = pcm_slot && (slot.grp == op_s4); // One S4 slot per frame for channel 5

    always_comb begin
        req_nxt.zero = slot.zero;
        if (use_pcm) begin
            req_nxt.sample = {~pcm[op_w-1], pcm[op_w-2:0]}; // Offset binary to signed
            req_nxt.rl     = cur_rl;               // PCM ignores the algorithm
        end else begin
            req_nxt.sample = op_result;
            // In PCM mode the other channel 5 slots stay out of the mix
            req_nxt.rl     = (carrier && !pcm_slot) ? cur_rl : 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req <= '0;
        end else if (clk_en) begin
            req <= req_nxt;                        // One enabled cycle behind the slot
        end
    end

endmodule

// File: design/fm_cfg_pkg.sv
package fm_cfg_pkg;

    localparam int num_ch   = 6;                   // Channels in one sample frame
    localparam int num_op   = 4;                   // Operators per channel
    localparam int num_slot = num_ch * num_op;     // Operator slots per frame, 24
    localparam int pcm_ch   = 5;                   // Channel that PCM data can replace

    localparam int op_w  = 9;                      // Signed operator result width
    localparam int snd_w = 12;                     // Signed accumulator and output width

    // Limits of the signed snd_w range, used by both limiters
    localparam logic signed [snd_w-1:0] snd_max = {1'b0, {(snd_w-1){1'b1}}};
    localparam logic signed [snd_w-1:0] snd_min = {1'b1, {(snd_w-1){1'b0}}};

    // Channel algorithm number as written in the channel configuration
    typedef enum logic [2:0] {
        alg0 = 3'd0,                               // Serial chain, S4 is the only carrier
        alg1 = 3'd1,
        alg2 = 3'd2,
        alg3 = 3'd3,
        alg4 = 3'd4,                               // Two pairs, S2 and S4 carry
        alg5 = 3'd5,                               // S1 modulates three carriers
        alg6 = 3'd6,
        alg7 = 3'd7                                // Four free-running carriers
    } fm_alg_e;

    // Operator groups numbered in the order they pass through the frame
    typedef enum logic [1:0] {
        op_s1 = 2'd0,                              // Slots 0 to 5
        op_s3 = 2'd1,                              // Slots 6 to 11
        op_s2 = 2'd2,                              // Slots 12 to 17
        op_s4 = 2'd3                               // Slots 18 to 23
    } fm_op_e;

endpackage

// File: design/fm_out_scale.sv
`timescale 1ns/10ps

module fm_out_scale (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  logic                zero,
    input  fm_bus_pkg::stereo_t pre,
    output fm_bus_pkg::stereo_t out,
    output logic                sample_valid
);
    import fm_cfg_pkg::*;

    logic zero_d;                                  // Accumulator outputs changed last enabled cycle

    // Gain of 1.25 as x + x/4, clamped to the output range
    function automatic logic signed [snd_w-1:0] boost(input logic signed [snd_w-1:0] x);
        logic signed [snd_w:0] wide;
        wide = {x[snd_w-1], x} + {{3{x[snd_w-1]}}, x[snd_w-1:2]};
        if (wide[snd_w] != wide[snd_w-1]) begin
            return wide[snd_w] ? snd_min : snd_max;
        end
        return wide[snd_w-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            zero_d       <= 1'b0;
            out          <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= clk_en && zero_d;      // Drops on the next clk even with clk_en low
            if (clk_en) begin
                zero_d <= zero;
                if (zero_d) begin
                    out.left  <= boost(pre.left);
                    out.right <= boost(pre.right);
                end
            end
        end
    end

endmodule

// File: design/fm_side_acc.sv
`timescale 1ns/10ps

module fm_side_acc (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clk_en,
    input  logic signed [fm_cfg_pkg::op_w-1:0]  sample,
    input  logic                                zero,
    input  logic                                sum_en,
    output logic signed [fm_cfg_pkg::snd_w-1:0] snd
);
    import fm_cfg_pkg::*;

    logic signed [snd_w-1:0] sum;                  // Running sum of the current frame
    logic signed [snd_w-1:0] ext;                  // Sample widened to the sum width
    logic signed [snd_w:0]   add;                  // One spare bit to see the overflow
    logic signed [snd_w-1:0] lim;                  // Sum after the limiter

    assign ext = {{(snd_w - op_w){sample[op_w-1]}}, sample};
    assign add = {sum[snd_w-1], sum} + {ext[snd_w-1], ext};

    // Top two bits disagree only when the true sum left the snd_w range
    always_comb begin
        if (add[snd_w] != add[snd_w-1]) begin
            lim = add[snd_w] ? snd_min : snd_max;  // Sign bit tells the direction
        end else begin
            lim = add[snd_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                snd <= sum;                        // Previous frame is complete
                sum <= sum_en ? ext : '0;          // Slot 0 opens the new frame
            end else if (sum_en) begin
                sum <= lim;
            end
        end
    end

endmodule

// File: design/fm_slot_seq.sv
`timescale 1ns/10ps

module fm_slot_seq (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clk_en,
    output fm_bus_pkg::slot_pos_t slot
);
    import fm_cfg_pkg::*;

    logic [4:0] slot_cnt;                          // Absolute slot number 0 to 23
    logic [2:0] ch_cnt;                            // Channel within the current group
    fm_op_e     grp;                               // Current operator group
    logic [1:0] grp_nxt;                           // Group number after the channel wrap

    // Groups are numbered in frame order, so stepping past S4 lands on S1
    assign grp_nxt = 2'(grp + 2'd1);

    // The slot counter and the channel and group counters advance together
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
            ch_cnt   <= '0;
            grp      <= op_s1;
        end else if (clk_en) begin
            if (slot_cnt == 5'(num_slot - 1)) begin
                slot_cnt <= '0;                    // Last slot of the frame
            end else begin
                slot_cnt <= slot_cnt + 5'd1;
            end
            if (ch_cnt == 3'(num_ch - 1)) begin
                ch_cnt <= '0;                      // Channel 5 done, next group starts
                grp    <= fm_op_e'(grp_nxt);
            end else begin
                ch_cnt <= ch_cnt + 3'd1;
            end
        end
    end

    assign slot.ch   = ch_cnt;
    assign slot.grp  = grp;
    assign slot.zero = (slot_cnt == 5'd0);         // Frame start marker for the whole chain

endmodule

// File: files.f
design/fm_cfg_pkg.sv
design/fm_bus_pkg.sv
design/fm_slot_seq.sv
design/fm_carrier_sel.sv
design/fm_side_acc.sv
design/fm_out_scale.sv
design/fm_acc_top.sv
sim/fm_acc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fm_acc_tb -f files.f \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vfm_acc_tb > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1

// File: sim/fm_acc_tb.sv
`timescale 1ns/10ps

module fm_acc_tb;
    import fm_cfg_pkg::*;
    import fm_bus_pkg::*;

    localparam int frame_cycles = 2 * num_slot;                  // Cycles in one frame at half rate
    localparam int max_cycles   = 8 * 6 * frame_cycles + 600; // Eight frames for each of six tests

    logic                   clk;
    logic                   rst;
    logic                   clk_en;
    logic signed [op_w-1:0] op_result;
    logic                   pcm_en;
    logic [op_w-1:0]        pcm;
    logic                   cfg_we;
    logic [2:0]             cfg_ch;
    fm_alg_e                cfg_alg;
    logic [1:0]             cfg_rl;
    stereo_t                snd;
    logic                   sample_valid;

    logic [31:0] rng         = 32'hc23d;          // LCG state
    int          slot_ctr    = 0;                 // Model slot position 0 to 23
    int          model_alg [num_ch];              // Mirror of the channel algorithm table
    int          model_rl  [num_ch];              // Mirror of the pan table
    int          acc_l       = 0;                 // Model running sums
    int          acc_r       = 0;
    stereo_t     exp_q [$];                       // Frame results still waiting for sample_valid
    string       cur_test    = "reset";
    int          checks      = 0;
    int          errors      = 0;
    int          test_checks = 0;                 // Counter values when the test started
    int          test_errors = 0;
    int          cycle_cnt   = 0;
    logic        valid_d     = 1'b0;              // sample_valid seen on the previous cycle

    fm_acc_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .clk_en       (clk_en),
        .op_result    (op_result),
        .pcm_en       (pcm_en),
        .pcm          (pcm),
        .cfg_we       (cfg_we),
        .cfg_ch       (cfg_ch),
        .cfg_alg      (cfg_alg),
        .cfg_rl       (cfg_rl),
        .snd          (snd),
        .sample_valid (sample_valid)
    );

    always #10 clk = ~clk;                        // 20 ns clock

    // Run limit counted in clk cycles from the start
    initial begin
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles in %s", cycle_cnt, cur_test);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic signed [op_w-1:0] next_random();
        rng = lcg_step(rng);
        return rng[24:16];                        // Middle bits since the low ones cycle fast
    endfunction

    // Saturate to the signed snd_w range
    function automatic int clamp(input int x);
        int hi;
        int lo;
        hi = (1 << (snd_w - 1)) - 1;
        lo = -(1 << (snd_w - 1));
        if (x > hi) begin
            return hi;
        end
        if (x < lo) begin
            return lo;
        end
        return x;
    endfunction

    function automatic int gain(input int x);
        return clamp(x + (x >>> 2));              // 1.25 with the quarter rounded down
    endfunction

    // Bit n-1 set when operator Sn of the algorithm is a carrier
    function automatic logic [3:0] carrier_mask(input int alg);
        if (alg == 7) begin
            return 4'b1111;
        end
        if (alg >= 5) begin
            return 4'b1110;                       // S2, S3 and S4
        end
        if (alg == 4) begin
            return 4'b1010;                       // S2 and S4
        end
        return 4'b1000;
    endfunction

    // Output monitor run once per clk cycle at the falling edge
    task automatic watch_outputs();
        stereo_t e;
        if (sample_valid) begin
            checks += 2;
            assert (!valid_d) else begin
                $display("sample_valid stayed high for two cycles in %s", cur_test);
                errors++;
            end
            assert (exp_q.size() != 0) else begin
                $display("sample_valid pulsed in %s with no frame due", cur_test);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checks += 2;
                assert (snd.left == e.left) else begin
                    $display("Fail %s left expected %0d actual %0d",
                             cur_test, e.left, snd.left);
                    errors++;
                end
                assert (snd.right == e.right) else begin
                    $display("Fail %s right expected %0d actual %0d",
                             cur_test, e.right, snd.right);
                    errors++;
                end
            end
        end
        valid_d = sample_valid;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        watch_outputs();
        @(posedge clk);
        #2;                                       // Inputs change just after the edge
    endtask

    // Reference frame model fed with what the DUT samples for this slot
    task automatic model_slot(input int op_val);
        int         ch;
        int         pos;
        int         op_num;
        int         sample;
        int         rl;
        logic [3:0] mask;
        stereo_t    e;
        ch  = slot_ctr % num_ch;
        pos = slot_ctr / num_ch;
        case (pos)                                // Frame order is S1, S3, S2, S4
            1:       op_num = 3;
            2:       op_num = 2;
            default: op_num = pos + 1;
        endcase
        if (slot_ctr == 0) begin
            e.left  = snd_w'(gain(acc_l));        // Previous frame closes here
            e.right = snd_w'(gain(acc_r));
            exp_q.push_back(e);
            acc_l = 0;
            acc_r = 0;
        end
        sample = op_val;
        rl     = 0;
        mask   = carrier_mask(model_alg[ch]);
        if (pcm_en && ch == pcm_ch) begin
            if (op_num == 4) begin
                sample = int'(pcm) - (1 << (op_w - 1)); // Offset binary around mid scale
                rl     = model_rl[ch];
            end
        end else if (mask[op_num-1]) begin
            rl = model_rl[ch];
        end
        if (rl[1]) begin
            acc_l = clamp(acc_l + sample);
        end
        if (rl[0]) begin
            acc_r = clamp(acc_r + sample);
        end
        slot_ctr = (slot_ctr + 1) % num_slot;
    endtask

    task automatic drive_slot(input logic signed [op_w-1:0] op_val, input bit half_rate);
        clk_en    = 1'b1;
        op_result = op_val;
        model_slot(int'(op_val));
        next_cycle();
        if (half_rate) begin
            clk_en    = 1'b0;
            op_result = ~op_val;                  // Junk that must be ignored
            next_cycle();
        end
    endtask

    task automatic run_frames(input int n, input bit half_rate);
        for (int i = 0; i < n * num_slot; i++) begin
            drive_slot(next_random(), half_rate);
        end
    endtask

    task automatic hold_value_frames(input int n, input logic signed [op_w-1:0] val);
        for (int i = 0; i < n * num_slot; i++) begin
            drive_slot(val, 1'b0);
        end
    endtask

    task automatic write_channel_cfg(input logic [2:0] ch, input fm_alg_e alg,
                                     input logic [1:0] rl);
        clk_en  = 1'b0;                           // No slot passes during the write
        cfg_we  = 1'b1;
        cfg_ch  = ch;
        cfg_alg = alg;
        cfg_rl  = rl;
        next_cycle();
        cfg_we        = 1'b0;
        model_alg[ch] = int'(alg);
        model_rl[ch]  = int'(rl);
    endtask

    task automatic set_all_channels(input fm_alg_e alg, input logic [1:0] rl);
        for (int c = 0; c < num_ch; c++) begin
            write_channel_cfg(3'(c), alg, rl);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    // A quiet frame lets the last frame of the test reach the output
    task automatic report_test();
        pcm_en = 1'b0;
        hold_value_frames(1, '0);
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("sample_valid missing for %0d frames in %s", exp_q.size(), cur_test);
            errors++;
            exp_q.delete();
        end
        $display("%s done, %0d checks, %0d errors",
                 cur_test, checks - test_checks, errors - test_errors);
    endtask

    task automatic check_reset_idle();
        start_test("reset_idle");
        repeat (8) begin
            clk_en    = 1'b0;
            op_result = next_random();            // Ignored with clk_en low
            next_cycle();
            checks++;
            assert (snd == '0 && !sample_valid) else begin
                $display("Fail %s expected 0 actual left %0d right %0d valid %0b",
                         cur_test, snd.left, snd.right, sample_valid);
                errors++;
            end
        end
        report_test();
    endtask

    task automatic sweep_algorithms();
        start_test("alg_carriers");
        for (int a = 0; a < 8; a++) begin
            set_all_channels(fm_alg_e'(3'(a)), 2'b11);
            run_frames(1, 1'b0);
        end
        report_test();
    endtask

    task automatic pan_channels();
        start_test("panning");
        for (int f = 0; f < 8; f++) begin
            for (int c = 0; c < num_ch; c++) begin
                write_channel_cfg(3'(c), fm_alg_e'(3'(c + f)), 2'((c + f) % 4)); // All four pans
            end
            run_frames(1, 1'b0);
        end
        report_test();
    endtask

    task automatic drive_full_scale();
        start_test("limiter");
        set_all_channels(alg7, 2'b11);
        hold_value_frames(4, 9'sh0ff);            // Largest positive operator value
        hold_value_frames(4, 9'sh100);            // Largest negative operator value
        report_test();
    endtask

    task automatic substitute_pcm();
        start_test("pcm");
        for (int c = 0; c < num_ch; c++) begin
            write_channel_cfg(3'(c), fm_alg_e'(3'(3 * c)), 2'(c % 3 + 1));
        end
        pcm_en = 1'b1;
        for (int f = 0; f < 4; f++) begin
            write_channel_cfg(3'(pcm_ch), fm_alg_e'(3'(7 - f)), 2'(f)); // Algorithm must not matter
            pcm = next_random();
            run_frames(1, 1'b0);
        end
        pcm_en = 1'b0;                            // Channel 5 back to normal FM
        run_frames(4, 1'b0);
        report_test();
    endtask

    task automatic halve_clock_enable();
        logic [31:0] saved;
        start_test("clock_enable");
        for (int c = 0; c < num_ch; c++) begin
            write_channel_cfg(3'(c), fm_alg_e'(3'(c + 2)), 2'(c % 4));
        end
        saved = rng;
        run_frames(4, 1'b0);
        rng = saved;                              // Same operator data again at half rate
        run_frames(4, 1'b1);
        report_test();
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        clk_en    = 1'b0;
        op_result = '0;
        pcm_en    = 1'b0;
        pcm       = '0;
        cfg_we    = 1'b0;
        cfg_ch    = '0;
        cfg_alg   = alg0;
        cfg_rl    = 2'b11;
        for (int c = 0; c < num_ch; c++) begin
            model_alg[c] = 0;                     // DUT reset state is alg0 on both sides
            model_rl[c]  = 3;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        check_reset_idle();
        sweep_algorithms();
        pan_channels();
        drive_full_scale();
        substitute_pcm();
        halve_clock_enable();

        $display("Totals %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
